/* src/mem_pkg.sv */
package mem_pkg;

    // **************************************************
    // Data path types
    // **************************************************
    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;    // Byte address, bits 1:0 ignored

    localparam int BYTE_OFS_W = 2;  // Byte offset inside a word

    // **************************************************
    // Instruction cache geometry
    // **************************************************
    localparam int WORDS_PER_LINE = 4;
    localparam int LINE_OFS_W     = $clog2(WORDS_PER_LINE);

    typedef logic [LINE_OFS_W-1:0] line_ofs_t;

    // **************************************************
    // Bus masters
    // **************************************************
    // 0 is the instruction cache, 1 the direct loader
    localparam int NUM_MASTERS = 2;

    typedef logic [$clog2(NUM_MASTERS)-1:0] master_id_t;

endpackage

/* src/bus_master_if.sv */
`timescale 1ns/10ps

interface bus_master_if import mem_pkg::*; ();

    logic  rreq;
    logic  wreq;
    addr_t addr;
    word_t wdata;
    word_t rdata;    // Valid together with acc
    logic  acc;      // One cycle, ends the transaction

    // Request side, held until acc
    modport master (
        output rreq,
        output wreq,
        output addr,
        output wdata,
        input  rdata,
        input  acc
    );

    modport arbiter (
        input  rreq,
        input  wreq,
        input  addr,
        input  wdata,
        output rdata,
        output acc
    );

endinterface

/* src/main_ram.sv */
`timescale 1ns/10ps

module main_ram import mem_pkg::*; #(
    parameter int RAM_WORDS = 1024
) (
    input  logic  clk,
    input  addr_t addr,
    input  word_t wdata,
    input  logic  rreq,
    input  logic  wreq,
    output word_t rdata
);

    localparam int IDX_W = (RAM_WORDS > 1) ? $clog2(RAM_WORDS) : 1;

    typedef logic [IDX_W-1:0] ram_idx_t;

    word_t    mem [RAM_WORDS];
    ram_idx_t idx_q;
    word_t    wdata_q;
    logic     rreq_q;
    logic     wreq_q;

    // Memory comes up cleared
    initial begin
        for (int i = 0; i < RAM_WORDS; i++) begin
            mem[i] = '0;
        end
    end

    // Request stage, word index wraps at the depth
    always_ff @(posedge clk) begin
        idx_q   <= ram_idx_t'(32'(addr[31:BYTE_OFS_W]) % RAM_WORDS);
        wdata_q <= wdata;
        rreq_q  <= rreq;
        wreq_q  <= wreq;
    end

    always_ff @(posedge clk) begin
        if (wreq_q) begin
            mem[idx_q] <= wdata_q;
        end
    end

    assign rdata = rreq_q ? mem[idx_q] : '0;    // One cycle after the request

endmodule

/* src/bus_arbiter.sv */
`timescale 1ns/10ps

module bus_arbiter import mem_pkg::*; (
    input  logic          clk,
    input  logic          rst_n,
    bus_master_if.arbiter m0,
    bus_master_if.arbiter m1,
    output addr_t         ram_addr,
    output word_t         ram_wdata,
    output logic          ram_rreq,
    output logic          ram_wreq,
    input  word_t         ram_rdata
);

    logic [NUM_MASTERS-1:0] req;
    master_id_t             sel;
    logic                   fwd;

    master_id_t gnt_q;
    logic       inflight_q;     // RAM answers in this cycle

    assign req[0] = m0.rreq || m0.wreq;
    assign req[1] = m1.rreq || m1.wreq;

    // Lowest index wins, only while nothing is open
    assign sel = req[0] ? master_id_t'(0) : master_id_t'(1);
    assign fwd = !inflight_q && (|req);

    // **************************************************
    // Request path to the RAM
    // **************************************************
    always_comb begin
        if (sel == master_id_t'(0)) begin
            ram_addr  = m0.addr;
            ram_wdata = m0.wdata;
            ram_rreq  = fwd && m0.rreq;
            ram_wreq  = fwd && m0.wreq;
        end else begin
            ram_addr  = m1.addr;
            ram_wdata = m1.wdata;
            ram_rreq  = fwd && m1.rreq;
            ram_wreq  = fwd && m1.wreq;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            inflight_q <= 1'b0;
            gnt_q      <= '0;
        end else begin
            inflight_q <= fwd;
            if (fwd) begin
                gnt_q <= sel;
            end
        end
    end

    // **************************************************
    // Answer path, granted master only
    // **************************************************
    assign m0.acc   = inflight_q && (gnt_q == master_id_t'(0));
    assign m1.acc   = inflight_q && (gnt_q == master_id_t'(1));
    assign m0.rdata = m0.acc ? ram_rdata : '0;
    assign m1.rdata = m1.acc ? ram_rdata : '0;

endmodule

/* src/icache.sv */
`timescale 1ns/10ps

module icache import mem_pkg::*; #(
    parameter int ICACHE_LINES = 16
) (
    input  logic         clk,
    input  logic         rst_n,
    input  logic         irreq,
    input  addr_t        iaddr,
    output word_t        irdata,
    output logic         imiss,
    bus_master_if.master bus
);

    localparam int IDX_W   = $clog2(ICACHE_LINES);
    localparam int IDX_LSB = BYTE_OFS_W + LINE_OFS_W;
    localparam int TAG_LSB = IDX_LSB + IDX_W;
    localparam int TAG_W   = 32 - TAG_LSB;

    typedef logic [IDX_W-1:0] line_idx_t;
    typedef logic [TAG_W-1:0] tag_t;

    typedef enum logic {
        ST_IDLE,
        ST_FILL
    } state_t;

    state_t                  state_q;
    logic [ICACHE_LINES-1:0] valid_q;
    tag_t                    tag_mem  [ICACHE_LINES];
    word_t                   data_mem [ICACHE_LINES][WORDS_PER_LINE];

    tag_t      req_tag;
    line_idx_t req_idx;
    line_ofs_t req_ofs;
    logic      hit;

    tag_t      fill_tag_q;
    line_idx_t fill_idx_q;
    line_ofs_t fill_ofs_q;
    logic      last_word;

    // **************************************************
    // Lookup, no clock in the path
    // **************************************************
    assign req_tag = iaddr[31:TAG_LSB];
    assign req_idx = iaddr[TAG_LSB-1:IDX_LSB];
    assign req_ofs = iaddr[IDX_LSB-1:BYTE_OFS_W];

    assign hit    = valid_q[req_idx] && (tag_mem[req_idx] == req_tag);
    assign imiss  = irreq && !hit;
    assign irdata = data_mem[req_idx][req_ofs];

    // **************************************************
    // Line refill
    // **************************************************
    assign bus.rreq  = (state_q == ST_FILL);
    assign bus.wreq  = 1'b0;    // Read only
    assign bus.wdata = '0;
    assign bus.addr  = {fill_tag_q, fill_idx_q, fill_ofs_q, {BYTE_OFS_W{1'b0}}};

    assign last_word = (fill_ofs_q == line_ofs_t'(WORDS_PER_LINE - 1));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q    <= ST_IDLE;
            valid_q    <= '0;
            fill_ofs_q <= '0;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (imiss) begin
                        state_q          <= ST_FILL;
                        valid_q[req_idx] <= 1'b0;   // Old line gives way
                        fill_ofs_q       <= '0;
                    end
                end
                ST_FILL: begin
                    if (bus.acc) begin
                        fill_ofs_q <= fill_ofs_q + line_ofs_t'(1);
                        if (last_word) begin
                            valid_q[fill_idx_q] <= 1'b1;
                            state_q             <= ST_IDLE;
                        end
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    // Line address captured at the start of a miss
    always_ff @(posedge clk) begin
        if (state_q == ST_IDLE && imiss) begin
            fill_tag_q <= req_tag;
            fill_idx_q <= req_idx;
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == ST_FILL && bus.acc) begin
            data_mem[fill_idx_q][fill_ofs_q] <= bus.rdata;
            if (last_word) begin
                tag_mem[fill_idx_q] <= fill_tag_q;
            end
        end
    end

endmodule

/* src/direct_loader.sv */
`timescale 1ns/10ps

module direct_loader import mem_pkg::*; (
    input  logic         clk,
    input  logic         rst_n,
    input  logic         drreq,
    input  logic         dwreq,
    input  addr_t        daddr,
    input  word_t        dwdata,
    output word_t        drdata,
    output logic         dmiss,
    bus_master_if.master bus
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WAIT_ACC,
        ST_DONE
    } state_t;

    state_t state_q;
    word_t  rdata_q;
    logic   core_req;
    logic   on_bus;

    assign core_req = drreq || dwreq;

    // Core holds its request, so it goes to the bus as is
    assign on_bus    = (state_q != ST_DONE);
    assign bus.rreq  = on_bus && drreq;
    assign bus.wreq  = on_bus && dwreq;
    assign bus.addr  = daddr;
    assign bus.wdata = dwdata;

    assign dmiss  = (state_q == ST_WAIT_ACC) || (state_q == ST_IDLE && core_req);
    assign drdata = rdata_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= ST_IDLE;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (core_req) begin
                        state_q <= ST_WAIT_ACC;
                    end
                end
                ST_WAIT_ACC: begin
                    if (bus.acc) begin
                        state_q <= ST_DONE;
                    end
                end
                default: state_q <= ST_IDLE;    // Done lasts one cycle
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (bus.acc) begin
            rdata_q <= bus.rdata;
        end
    end

endmodule

/* src/memory_system.sv */
`timescale 1ns/10ps

module memory_system import mem_pkg::*; #(
    parameter int ICACHE_LINES = 16,
    parameter int RAM_WORDS    = 1024
) (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  irreq,
    input  addr_t iaddr,
    output word_t irdata,
    output logic  imiss,
    input  logic  drreq,
    input  logic  dwreq,
    input  addr_t daddr,
    input  word_t dwdata,
    output word_t drdata,
    output logic  dmiss
);

    // **************************************************
    // Shared bus
    // **************************************************
    bus_master_if mbus [NUM_MASTERS] ();    // 0 icache, 1 loader

    addr_t ram_addr;
    word_t ram_wdata;
    word_t ram_rdata;
    logic  ram_rreq;
    logic  ram_wreq;

    bus_arbiter u_arbiter (
        .clk       (clk),
        .rst_n     (rst_n),
        .m0        (mbus[0]),
        .m1        (mbus[1]),
        .ram_addr  (ram_addr),
        .ram_wdata (ram_wdata),
        .ram_rreq  (ram_rreq),
        .ram_wreq  (ram_wreq),
        .ram_rdata (ram_rdata)
    );

    main_ram #(.RAM_WORDS(RAM_WORDS)) u_ram (
        .clk   (clk),
        .addr  (ram_addr),
        .wdata (ram_wdata),
        .rreq  (ram_rreq),
        .wreq  (ram_wreq),
        .rdata (ram_rdata)
    );

    // **************************************************
    // Core ports
    // **************************************************
    icache #(.ICACHE_LINES(ICACHE_LINES)) u_icache (
        .clk    (clk),
        .rst_n  (rst_n),
        .irreq  (irreq),
        .iaddr  (iaddr),
        .irdata (irdata),
        .imiss  (imiss),
        .bus    (mbus[0])
    );

    // Data side is uncached
    direct_loader u_loader (
        .clk    (clk),
        .rst_n  (rst_n),
        .drreq  (drreq),
        .dwreq  (dwreq),
        .daddr  (daddr),
        .dwdata (dwdata),
        .drdata (drdata),
        .dmiss  (dmiss),
        .bus    (mbus[1])
    );

endmodule

/* tb/memory_system_asserts.sv */
`timescale 1ns/10ps

module memory_system_asserts import mem_pkg::*; (
    input logic  clk,
    input logic  rst_n,
    input logic  m0_req,
    input logic  m1_req,
    input addr_t m0_addr,
    input addr_t m1_addr,
    input logic  m0_acc,
    input logic  m1_acc,
    input logic  fwd        // Request passed on to the RAM
);

    // **************************************************
    // Arbiter handshake
    // **************************************************
    one_acc: assert property (@(posedge clk) disable iff (!rst_n)
        !(m0_acc && m1_acc))
        else $error("acc high on both masters");

    m0_addr_held: assert property (@(posedge clk) disable iff (!rst_n)
        m0_req && !m0_acc |=> $stable(m0_addr))
        else $error("master 0 address changed before acc");

    m1_addr_held: assert property (@(posedge clk) disable iff (!rst_n)
        m1_req && !m1_acc |=> $stable(m1_addr))
        else $error("master 1 address changed before acc");

    acc_after_fwd: assert property (@(posedge clk) disable iff (!rst_n)
        fwd |=> (m0_acc || m1_acc))
        else $error("no acc one cycle after a forwarded request");

    acc_needs_fwd: assert property (@(posedge clk) disable iff (!rst_n)
        (m0_acc || m1_acc) |-> $past(fwd))
        else $error("acc without a request forwarded in the cycle before");

endmodule

bind bus_arbiter memory_system_asserts u_asserts (
    .clk     (clk),
    .rst_n   (rst_n),
    .m0_req  (req[0]),
    .m1_req  (req[1]),
    .m0_addr (m0.addr),
    .m1_addr (m1.addr),
    .m0_acc  (m0.acc),
    .m1_acc  (m1.acc),
    .fwd     (ram_rreq || ram_wreq)
);

/* tb/tb_memory_system.sv */
`timescale 1ns/10ps

module tb_memory_system import mem_pkg::*; ();

    localparam int ICACHE_LINES = 16;
    localparam int RAM_WORDS    = 1024;
    localparam int CLK_HALF     = 20;

    localparam bit PORT_D = 1'b1;
    localparam bit PORT_I = 1'b0;
    localparam bit WR     = 1'b1;
    localparam bit RD     = 1'b0;

    typedef struct {
        bit    is_d;
        bit    wr;
        bit    par;         // Runs together with the next entry
        bit    exp_miss;
        addr_t addr;
        word_t wdata;
        word_t exp;
    } op_t;

    logic  clk = 1'b0;
    logic  rst_n;
    logic  irreq;
    addr_t iaddr;
    word_t irdata;
    logic  imiss;
    logic  drreq;
    logic  dwreq;
    addr_t daddr;
    word_t dwdata;
    word_t drdata;
    logic  dmiss;

    word_t       ref_mem  [RAM_WORDS];
    bit          sh_valid [ICACHE_LINES];
    int unsigned sh_line  [ICACHE_LINES];   // Line number held by each slot
    word_t       sh_data  [ICACHE_LINES][WORDS_PER_LINE];
    op_t         ops[$];
    int          errors = 0;

    memory_system #(
        .ICACHE_LINES (ICACHE_LINES),
        .RAM_WORDS    (RAM_WORDS)
    ) dut (
        .clk    (clk),
        .rst_n  (rst_n),
        .irreq  (irreq),
        .iaddr  (iaddr),
        .irdata (irdata),
        .imiss  (imiss),
        .drreq  (drreq),
        .dwreq  (dwreq),
        .daddr  (daddr),
        .dwdata (dwdata),
        .drdata (drdata),
        .dmiss  (dmiss)
    );

    always #CLK_HALF clk = !clk;

    // **************************************************
    // Reference models
    // **************************************************
    function automatic int word_idx(addr_t a);
        return int'((a >> 2) % RAM_WORDS);
    endfunction

    // Expected values come from the models at the time the entry is added
    function automatic void add_op(bit is_d, bit wr, addr_t a, word_t wd, bit par);
        op_t         op;
        int unsigned line;
        int          idx;
        op.is_d     = is_d;
        op.wr       = wr;
        op.par      = par;
        op.addr     = a;
        op.wdata    = wd;
        op.exp      = '0;
        op.exp_miss = 1'b0;
        if (is_d && wr) begin
            ref_mem[word_idx(a)] = wd;
        end else if (is_d) begin
            op.exp = ref_mem[word_idx(a)];
        end else begin
            line = a >> 4;
            idx  = int'(line % ICACHE_LINES);
            op.exp_miss = !(sh_valid[idx] && sh_line[idx] == line);
            if (op.exp_miss) begin
                for (int w = 0; w < WORDS_PER_LINE; w++) begin
                    sh_data[idx][w] = ref_mem[word_idx((a & ~32'hF) + addr_t'(4 * w))];
                end
                sh_valid[idx] = 1'b1;
                sh_line[idx]  = line;
            end
            op.exp = sh_data[idx][int'((a >> 2) % WORDS_PER_LINE)];
        end
        ops.push_back(op);
    endfunction

    // **************************************************
    // Port drivers
    // **************************************************
    task automatic run_d(input op_t op);
        @(posedge clk);
        drreq  <= !op.wr;
        dwreq  <= op.wr;
        daddr  <= op.addr;
        dwdata <= op.wdata;
        @(negedge clk);
        if (dmiss !== 1'b1) begin
            errors++;
            $display("error at %0t: dmiss = %b, expected 1", $time, dmiss);
        end
        while (dmiss) begin
            @(negedge clk);
        end
        if (!op.wr && drdata !== op.exp) begin
            errors++;
            $display("error at %0t: drdata = %h, expected %h", $time, drdata, op.exp);
        end
        @(posedge clk);
        drreq <= 1'b0;
        dwreq <= 1'b0;
    endtask

    task automatic run_i(input op_t op);
        @(posedge clk);
        irreq <= 1'b1;
        iaddr <= op.addr;
        @(negedge clk);
        if (imiss !== op.exp_miss) begin    // Hit must answer in this cycle
            errors++;
            $display("error at %0t: imiss = %b, expected %b", $time, imiss, op.exp_miss);
        end
        while (imiss) begin
            @(negedge clk);
        end
        if (irdata !== op.exp) begin
            errors++;
            $display("error at %0t: irdata = %h, expected %h", $time, irdata, op.exp);
        end
        @(posedge clk);
        irreq <= 1'b0;
    endtask

    initial begin
        int    i;
        addr_t a;
        rst_n  = 1'b0;
        irreq  = 1'b0;
        iaddr  = '0;
        drreq  = 1'b0;
        dwreq  = 1'b0;
        daddr  = '0;
        dwdata = '0;
        void'($urandom(38));
        for (int k = 0; k < RAM_WORDS; k++) begin
            ref_mem[k] = '0;
        end
        for (int k = 0; k < ICACHE_LINES; k++) begin
            sh_valid[k] = 1'b0;
        end

        // **************************************************
        // Operation table
        // **************************************************
        add_op(PORT_D, WR, 32'h100, $urandom(), 1'b0);
        add_op(PORT_D, WR, 32'h104, $urandom(), 1'b0);
        add_op(PORT_D, RD, 32'h100, '0, 1'b0);
        add_op(PORT_D, RD, 32'h104, '0, 1'b0);
        for (int w = 0; w < WORDS_PER_LINE; w++) begin
            add_op(PORT_D, WR, addr_t'(32'h040 + 4 * w), $urandom(), 1'b0);
            add_op(PORT_D, WR, addr_t'(32'h140 + 4 * w), $urandom(), 1'b0);
        end
        add_op(PORT_I, RD, 32'h048, '0, 1'b0);     // Line fill
        add_op(PORT_I, RD, 32'h040, '0, 1'b0);
        add_op(PORT_I, RD, 32'h044, '0, 1'b0);
        add_op(PORT_I, RD, 32'h04C, '0, 1'b0);
        add_op(PORT_I, RD, 32'h144, '0, 1'b0);     // Same index, other tag
        add_op(PORT_I, RD, 32'h040, '0, 1'b0);
        // Stale word stays until the line is refilled
        add_op(PORT_D, WR, 32'h044, $urandom(), 1'b0);
        add_op(PORT_I, RD, 32'h044, '0, 1'b0);
        add_op(PORT_I, RD, 32'h14C, '0, 1'b0);
        add_op(PORT_I, RD, 32'h044, '0, 1'b0);
        // Both ports at once, data region kept apart from fetches
        for (int n = 0; n < 20; n++) begin
            a = addr_t'(32'h800 + 4 * ($urandom() % 128));
            add_op(PORT_D, ($urandom() % 2) == 0, a, $urandom(), 1'b1);
            add_op(PORT_I, RD, addr_t'(4 * ($urandom() % 128)), '0, 1'b0);
        end

        fork
            begin
                #(ops.size() * 40 * 2 * CLK_HALF);
                $display("timeout: run did not finish within %0d cycles", ops.size() * 40);
                $display("errors: %0d", errors);
                $display("tests failed");
                $finish;
            end
        join_none

        repeat (10) @(posedge clk);
        rst_n <= 1'b1;

        i = 0;
        while (i < ops.size()) begin
            if (ops[i].par) begin
                fork
                    begin
                        // Late data request meets a refill already on the bus
                        repeat ($urandom() % 3) @(posedge clk);
                        run_d(ops[i]);
                    end
                    run_i(ops[i + 1]);
                join
                i += 2;
            end else if (ops[i].is_d) begin
                run_d(ops[i]);
                i++;
            end else begin
                run_i(ops[i]);
                i++;
            end
        end

        repeat (2) @(posedge clk);
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

/* compile.f */
src/mem_pkg.sv
src/bus_master_if.sv
src/main_ram.sv
src/bus_arbiter.sv
src/icache.sv
src/direct_loader.sv
src/memory_system.sv
tb/memory_system_asserts.sv
tb/tb_memory_system.sv

/* Makefile */
TOP = tb_memory_system
LOG = sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing --assert --top-module $(TOP) -f compile.f

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f compile.f -o $(TOP)
	./obj_dir/$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "tests failed" $(LOG); then echo "simulation FAILED"; exit 1; fi
	@if ! grep -q "all tests passed" $(LOG); then echo "simulation ended early"; exit 1; fi

clean:
	rm -rf obj_dir $(LOG)
